// ==== Bender.yml ====
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/cache_set_store.sv
  - logic/way_lookup.sv
  - logic/line_update.sv
  - logic/cache_ctrl_fsm.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - sim/cache_properties.sv
      - sim/cache_checker.sv
      - sim/cache_tb.sv

// ==== flist.f ====
logic/cache_pkg.sv
logic/cache_set_store.sv
logic/way_lookup.sv
logic/line_update.sv
logic/cache_ctrl_fsm.sv
logic/cache_top.sv
sim/cache_properties.sv
sim/cache_checker.sv
sim/cache_tb.sv

// ==== logic/cache_ctrl_fsm.sv ====
`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic cpu_valid,
  output logic cpu_ack,
  input  logic hit,
  input  logic victim_dirty,
  input  logic mem_ack,
  output logic mem_valid,
  output logic mem_write,
  output logic rd_en,
  output logic wr_en,
  output logic fill_en,
  output logic req_en
);

  cache_pkg::ctrl_state_e state;
  cache_pkg::ctrl_state_e next_state;

  logic cpu_ack_q;
  logic mem_valid_q;
  logic mem_wait_q;   // Memory acked, waiting for mem_ack to drop
  logic mem_start;
  logic mem_ack_seen;
  logic mem_leave;

  assign mem_ack_seen = mem_valid_q && mem_ack;
  assign mem_leave    = mem_wait_q && !mem_ack;  // Four-phase cycle complete

  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::IDLE: begin
        if (cpu_valid) next_state = cache_pkg::LOOKUP;
      end
      cache_pkg::LOOKUP: begin
        if (hit)
          next_state = cache_pkg::UPDATE;
        else if (victim_dirty)
          next_state = cache_pkg::EVICT;  // Write back first
        else
          next_state = cache_pkg::ALLOCATE;
      end
      cache_pkg::EVICT: begin
        if (mem_leave) next_state = cache_pkg::ALLOCATE;
      end
      cache_pkg::ALLOCATE: begin
        if (mem_leave) next_state = cache_pkg::UPDATE;
      end
      cache_pkg::UPDATE: begin
        next_state = cache_pkg::RESPOND;
      end
      cache_pkg::RESPOND: begin
        if (cpu_ack_q && !cpu_valid) next_state = cache_pkg::IDLE;
      end
      default: begin
        next_state = cache_pkg::IDLE;
      end
    endcase
  end

  // Raise mem_valid on entry to a memory state
  assign mem_start = (next_state != state) &&
                     ((next_state == cache_pkg::EVICT) || (next_state == cache_pkg::ALLOCATE));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= cache_pkg::IDLE;
      cpu_ack_q   <= 1'b0;
      mem_valid_q <= 1'b0;
      mem_wait_q  <= 1'b0;
    end else begin
      state <= next_state;
      // Ack one cycle into RESPOND, dropped once cpu_valid falls
      cpu_ack_q <= (state == cache_pkg::RESPOND) && (next_state == cache_pkg::RESPOND);

      if (mem_start)
        mem_valid_q <= 1'b1;
      else if (mem_ack_seen)
        mem_valid_q <= 1'b0;

      if (mem_ack_seen)
        mem_wait_q <= 1'b1;
      else if (mem_leave)
        mem_wait_q <= 1'b0;
    end
  end

  assign cpu_ack   = cpu_ack_q;
  assign mem_valid = mem_valid_q;
  assign mem_write = (state == cache_pkg::EVICT);

  // Store read and request capture share the accept cycle
  assign rd_en   = (state == cache_pkg::IDLE) && cpu_valid;
  assign req_en  = (state == cache_pkg::IDLE) && cpu_valid;
  assign wr_en   = (state == cache_pkg::UPDATE);
  assign fill_en = (state == cache_pkg::ALLOCATE) && mem_ack_seen;  // Line valid with mem_ack

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

  // Geometry of the cache
  localparam int unsigned word_w     = 32;
  localparam int unsigned line_words = 4;
  localparam int unsigned offset_w   = 2;
  localparam int unsigned num_sets   = 16;
  localparam int unsigned index_w    = 4;
  localparam int unsigned num_ways   = 4;
  localparam int unsigned tag_w      = word_w - index_w - offset_w;  // 26 bits
  localparam int unsigned age_w      = 2;

  typedef logic [word_w-1:0] word_t;
  typedef logic [line_words-1:0][word_w-1:0] line_data_t;  // Word 0 in the low bits

  // Word address split into its fields
  typedef struct packed {
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
  } addr_fields_t;

  // Same address word, raw or decoded
  typedef union packed {
    word_t        raw;
    addr_fields_t f;
  } cache_addr_u;

  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [age_w-1:0] age;    // 0 is most recently used
    logic [tag_w-1:0] tag;
  } way_meta_t;

  typedef struct packed {
    way_meta_t  meta;
    line_data_t data;
  } way_entry_t;

  typedef way_entry_t [num_ways-1:0] set_entry_t;  // All four candidates of one set

  typedef logic [num_ways-1:0] way_sel_t;  // One-hot

  typedef struct packed {
    logic        write;
    cache_addr_u addr;
    word_t       wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                     write;
    logic [tag_w+index_w-1:0] line_addr;  // Tag and index of the block
    line_data_t               data;
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    ALLOCATE,
    UPDATE,
    RESPOND
  } ctrl_state_e;

endpackage

// ==== logic/cache_set_store.sv ====
`timescale 1ns/1ps

module cache_set_store (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  rd_en,
  input  logic                                                  wr_en,
  input  logic [cache_pkg::index_w-1:0]                         index,
  input  cache_pkg::way_sel_t                                   wr_way,
  input  cache_pkg::way_entry_t                                 wr_entry,
  input  logic [cache_pkg::num_ways-1:0][cache_pkg::age_w-1:0]  new_ages,
  output cache_pkg::set_entry_t                                 cand
);

  // Meta state per set and way
  cache_pkg::way_meta_t  meta_q [cache_pkg::num_sets][cache_pkg::num_ways];
  cache_pkg::line_data_t data_q [cache_pkg::num_sets][cache_pkg::num_ways];

  // Valid, dirty and ages, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
          meta_q[s][w].valid <= 1'b0;
          meta_q[s][w].dirty <= 1'b0;
          meta_q[s][w].age   <= w[cache_pkg::age_w-1:0];  // Ways start at ages 0..3
          meta_q[s][w].tag   <= '0;
        end
      end
    end else if (wr_en) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        meta_q[index][w].age <= new_ages[w];  // Every way of the set gets its new age
        if (wr_way[w]) begin
          meta_q[index][w].valid <= wr_entry.meta.valid;
          meta_q[index][w].dirty <= wr_entry.meta.dirty;
          meta_q[index][w].tag   <= wr_entry.meta.tag;
        end
      end
    end
  end

  // Line data
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        if (wr_way[w]) begin
          data_q[index][w] <= wr_entry.data;
        end
      end
    end
  end

  // Registered read of the addressed set
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        cand[w].meta <= meta_q[index][w];
        cand[w].data <= data_q[index][w];
      end
    end
  end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::cpu_req_t    cpu_req,
  input  logic                   cpu_valid,
  output logic                   cpu_ack,
  output cache_pkg::word_t       cpu_rdata,
  output cache_pkg::mem_req_t    mem_req,
  output logic                   mem_valid,
  input  logic                   mem_ack,
  input  cache_pkg::line_data_t  mem_rdata
);

  cache_pkg::cpu_req_t    req_q;
  cache_pkg::line_data_t  fill_q;
  cache_pkg::set_entry_t  cand;
  cache_pkg::way_entry_t  wr_entry;
  cache_pkg::way_sel_t    hit_way;
  cache_pkg::way_sel_t    victim_way;
  cache_pkg::way_entry_t  victim;
  logic [cache_pkg::num_ways-1:0][cache_pkg::age_w-1:0] new_ages;
  logic [cache_pkg::index_w-1:0] index;
  logic hit, victim_dirty, mem_write;
  logic rd_en, wr_en, fill_en, req_en;

  always_ff @(posedge clk) begin
    if (req_en) req_q <= cpu_req;
    if (fill_en) fill_q <= mem_rdata;
  end

  // Read uses the live request, since req_q loads on the same edge
  assign index = rd_en ? cpu_req.addr.f.index : req_q.addr.f.index;

  always_comb begin
    victim = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (victim_way[w]) victim = cand[w];
    end
  end

  assign mem_req.write     = mem_write;
  assign mem_req.line_addr = mem_write ? {victim.meta.tag, req_q.addr.f.index}
                                       : {req_q.addr.f.tag, req_q.addr.f.index};
  assign mem_req.data      = mem_write ? victim.data : '0;

  cache_set_store u_store (
    .clk, .rst_n, .rd_en, .wr_en, .index,
    .wr_way   (hit ? hit_way : victim_way),
    .wr_entry, .new_ages, .cand
  );

  way_lookup u_lookup (
    .cand, .req_tag (req_q.addr.f.tag),
    .hit, .hit_way, .victim_way, .victim_dirty, .new_ages
  );

  line_update u_line (
    .cpu_req (req_q), .hit, .hit_way, .cand,
    .fill_line (fill_q), .wr_entry, .rdata (cpu_rdata)
  );

  cache_ctrl_fsm u_fsm (
    .clk, .rst_n, .cpu_valid, .cpu_ack, .hit, .victim_dirty,
    .mem_ack, .mem_valid, .mem_write, .rd_en, .wr_en, .fill_en, .req_en
  );

endmodule

// ==== logic/line_update.sv ====
`timescale 1ns/1ps

module line_update (
  input  cache_pkg::cpu_req_t    cpu_req,
  input  logic                   hit,
  input  cache_pkg::way_sel_t    hit_way,
  input  cache_pkg::set_entry_t  cand,
  input  cache_pkg::line_data_t  fill_line,
  output cache_pkg::way_entry_t  wr_entry,
  output cache_pkg::word_t       rdata
);

  cache_pkg::line_data_t hit_line;
  cache_pkg::line_data_t merged;
  logic                  hit_dirty;

  // Data and dirty flag of the hit way
  always_comb begin
    hit_line  = '0;
    hit_dirty = 1'b0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (hit_way[w]) begin
        hit_line  = cand[w].data;
        hit_dirty = cand[w].meta.dirty;
      end
    end
  end

  always_comb begin
    merged = hit ? hit_line : fill_line;  // Miss takes the line fetched from memory
    if (cpu_req.write) merged[cpu_req.addr.f.offset] = cpu_req.wdata;
  end

  always_comb begin
    wr_entry.meta.valid = 1'b1;
    wr_entry.meta.dirty = cpu_req.write | (hit & hit_dirty);  // Read miss comes in clean
    wr_entry.meta.age   = '0;                                // Store takes ages from lookup
    wr_entry.meta.tag   = cpu_req.addr.f.tag;
    wr_entry.data       = merged;
  end

  assign rdata = merged[cpu_req.addr.f.offset];

endmodule

// ==== logic/way_lookup.sv ====
`timescale 1ns/1ps

module way_lookup (
  input  cache_pkg::set_entry_t                                 cand,
  input  logic [cache_pkg::tag_w-1:0]                           req_tag,
  output logic                                                  hit,
  output cache_pkg::way_sel_t                                   hit_way,
  output cache_pkg::way_sel_t                                   victim_way,
  output logic                                                  victim_dirty,
  output logic [cache_pkg::num_ways-1:0][cache_pkg::age_w-1:0]  new_ages
);

  cache_pkg::way_sel_t             valid_vec;
  cache_pkg::way_sel_t             dirty_vec;
  cache_pkg::way_sel_t             acc_way;   // Way touched by this access
  logic [cache_pkg::age_w-1:0]     acc_age;

  always_comb begin
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      valid_vec[w] = cand[w].meta.valid;
      dirty_vec[w] = cand[w].meta.dirty;
      hit_way[w]   = cand[w].meta.valid && (cand[w].meta.tag == req_tag);
    end
  end

  assign hit = |hit_way;

  // Lowest invalid way first, else the oldest one
  always_comb begin
    logic found;
    found      = 1'b0;
    victim_way = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (!valid_vec[w] && !found) begin
        victim_way[w] = 1'b1;
        found         = 1'b1;
      end
    end
    if (!found) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        victim_way[w] = (cand[w].meta.age == '1);
      end
    end
  end

  assign victim_dirty = |(victim_way & valid_vec & dirty_vec);
  assign acc_way      = hit ? hit_way : victim_way;

  // Old age of the accessed way
  always_comb begin
    acc_age = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (acc_way[w]) acc_age = cand[w].meta.age;
    end
  end

  // Accessed way becomes youngest, younger ones age by one
  always_comb begin
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (acc_way[w])
        new_ages[w] = '0;
      else if (cand[w].meta.age < acc_age)
        new_ages[w] = cand[w].meta.age + 1'b1;
      else
        new_ages[w] = cand[w].meta.age;
    end
  end

endmodule

// ==== sim/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::cpu_req_t cpu_req,
  input  logic                cpu_valid,
  input  logic                cpu_ack,
  input  cache_pkg::word_t    cpu_rdata,
  input  cache_pkg::mem_req_t mem_req,
  input  logic                mem_valid,
  output int                  errors,
  output int                  checks,
  output int                  completed
);

  localparam int hit_ack_edges = 4;  // Rise after edge 3, seen at edge 4

  // Flat word model over tag[2:0], index[1:0], offset
  cache_pkg::word_t flat_word [128];
  logic             flat_written [128];

  // Shadow of tags, flags and ages per set and way
  logic                          sh_valid [cache_pkg::num_sets][cache_pkg::num_ways];
  logic                          sh_dirty [cache_pkg::num_sets][cache_pkg::num_ways];
  logic [cache_pkg::age_w-1:0]   sh_age   [cache_pkg::num_sets][cache_pkg::num_ways];
  logic [cache_pkg::tag_w-1:0]   sh_tag   [cache_pkg::num_sets][cache_pkg::num_ways];

  cache_pkg::cpu_req_t req;  // Request in flight
  logic busy, ack_seen, pred_hit, exp_wb, mem_valid_d;
  logic [cache_pkg::tag_w+cache_pkg::index_w-1:0] wb_line;
  int   lat, mem_ops;

  // Initial memory contents, mixed from the whole word address
  function automatic cache_pkg::word_t init_word(cache_pkg::word_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  function automatic int flat_key(cache_pkg::cache_addr_u a);
    return {a.f.tag[2:0], a.f.index[1:0], a.f.offset};
  endfunction

  function automatic cache_pkg::word_t model_word(cache_pkg::word_t addr);
    cache_pkg::cache_addr_u a;
    a.raw = addr;
    return flat_written[flat_key(a)] ? flat_word[flat_key(a)] : init_word(addr);
  endfunction

  function automatic cache_pkg::line_data_t model_line(logic [29:0] line_addr);
    cache_pkg::line_data_t line;
    for (int w = 0; w < cache_pkg::line_words; w++) begin
      line[w] = model_word({line_addr, w[1:0]});
    end
    return line;
  endfunction

  task automatic compare_value(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("FAIL %s exp=%0h got=%0h", name, exp, got);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("%s at %0t ns", what, $time);
  endtask

  // Hit or victim choice and LRU update on the shadow
  task automatic predict_access(input cache_pkg::cpu_req_t r);
    int   idx;
    int   acc;
    int   old_age;
    logic found;
    idx      = r.addr.f.index;
    acc      = 0;
    found    = 1'b0;
    pred_hit = 1'b0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (sh_valid[idx][w] && sh_tag[idx][w] == r.addr.f.tag) begin
        pred_hit = 1'b1;
        acc      = w;
      end
    end
    if (!pred_hit) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        if (!sh_valid[idx][w] && !found) begin
          acc   = w;
          found = 1'b1;
        end
      end
      if (!found) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
          if (sh_age[idx][w] == 3) acc = w;  // Oldest way
        end
      end
    end
    exp_wb  = !pred_hit && sh_valid[idx][acc] && sh_dirty[idx][acc];
    wb_line = {sh_tag[idx][acc], r.addr.f.index};
    old_age = sh_age[idx][acc];
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (w == acc) sh_age[idx][w] = '0;
      else if (sh_age[idx][w] < old_age) sh_age[idx][w] = sh_age[idx][w] + 1'b1;
    end
    sh_dirty[idx][acc] = r.write || (pred_hit && sh_dirty[idx][acc]);
    sh_valid[idx][acc] = 1'b1;
    sh_tag[idx][acc]   = r.addr.f.tag;
  endtask

  task automatic check_mem_request();
    if (!busy) begin
      report_problem("Memory request with no CPU request in flight");
    end else if (pred_hit) begin
      report_problem("Memory request during a predicted hit");
    end else begin
      if (exp_wb && mem_ops == 0) begin  // Dirty victim goes out first
        compare_value("mem_req.write", 1'b1, mem_req.write);
        compare_value("mem_req.line_addr", wb_line, mem_req.line_addr);
        compare_value("mem_req.data", model_line(wb_line), mem_req.data);
      end else begin
        compare_value("mem_req.write", 1'b0, mem_req.write);
        compare_value("mem_req.line_addr", {req.addr.f.tag, req.addr.f.index},
                      mem_req.line_addr);
      end
      mem_ops++;
    end
  endtask

  task automatic check_response();
    int key;
    ack_seen = 1'b1;
    completed++;
    checks++;
    if (pred_hit && lat != hit_ack_edges)
      report_problem($sformatf("Hit acknowledged %0d cycles after acceptance, not 3", lat - 1));
    if (!pred_hit && mem_ops != (exp_wb ? 2 : 1))
      report_problem($sformatf("Miss made %0d memory requests, expected %0d",
                               mem_ops, exp_wb ? 2 : 1));
    key = flat_key(req.addr);
    if (req.write) begin
      compare_value("cpu_rdata", req.wdata, cpu_rdata);
      flat_word[key]    = req.wdata;
      flat_written[key] = 1'b1;
    end else begin
      compare_value("cpu_rdata", model_word(req.addr.raw), cpu_rdata);
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
          sh_valid[s][w] = 1'b0;
          sh_dirty[s][w] = 1'b0;
          sh_age[s][w]   = w[cache_pkg::age_w-1:0];
          sh_tag[s][w]   = '0;
        end
      end
      for (int k = 0; k < 128; k++) flat_written[k] = 1'b0;
      busy        = 1'b0;
      ack_seen    = 1'b0;
      mem_valid_d = 1'b0;
      errors      = 0;
      checks      = 0;
      completed   = 0;
    end else begin
      if (cpu_ack && !busy) report_problem("cpu_ack high with no request in flight");
      if (!busy && cpu_valid) begin  // FSM accepts in IDLE on this edge
        busy      = 1'b1;
        req       = cpu_req;
        lat       = 0;
        ack_seen  = 1'b0;
        mem_ops   = 0;
        predict_access(cpu_req);
      end else if (busy) begin
        lat++;
      end
      if (mem_valid && !mem_valid_d) check_mem_request();
      if (busy && cpu_ack && !ack_seen) check_response();
      if (busy && ack_seen && cpu_ack && !cpu_valid) busy = 1'b0;  // FSM back to IDLE
      mem_valid_d = mem_valid;
    end
  end

endmodule

// ==== sim/cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties (
  input logic                clk,
  input logic                rst_n,
  input logic                cpu_valid,
  input logic                cpu_ack,
  input cache_pkg::mem_req_t mem_req,
  input logic                mem_valid,
  input logic                mem_ack
);

  int fail_count = 0;  // Summed into the closing count line

  // Both handshakes idle coming out of reset
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !cpu_ack && !mem_valid)
    else begin
      fail_count++;
      $error("cpu_ack or mem_valid high after reset");
    end

  mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_ack |=> $stable(mem_req))
    else begin
      fail_count++;
      $error("mem_req changed while waiting for mem_ack");
    end

  mem_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_ack |=> mem_valid)
    else begin
      fail_count++;
      $error("mem_valid dropped before mem_ack rose");
    end

  cpu_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_ack && cpu_valid |=> cpu_ack)
    else begin
      fail_count++;
      $error("cpu_ack dropped while cpu_valid was still high");
    end

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

  localparam int num_reqs       = 400;
  localparam int max_req_cycles = 60;  // Worst case for evict plus allocate
  localparam int clk_period_ns  = 8;
  localparam int watchdog_ns    = num_reqs * max_req_cycles * clk_period_ns;

  logic                  clk = 1'b0;
  logic                  rst_n;
  cache_pkg::cpu_req_t   cpu_req;
  logic                  cpu_valid;
  logic                  cpu_ack;
  cache_pkg::word_t      cpu_rdata;
  cache_pkg::mem_req_t   mem_req;
  logic                  mem_valid;
  logic                  mem_ack;
  cache_pkg::line_data_t mem_rdata;

  int errors, checks, completed;
  int seed = 31;
  cache_pkg::word_t      rnd;
  cache_pkg::line_data_t mem_lines [32];  // 8 tags x 4 sets
  int   mem_delay;
  logic mem_pending;
  int   line_key;

  always #(clk_period_ns / 2) clk = ~clk;

  cache_top DUT (
    .clk, .rst_n, .cpu_req, .cpu_valid, .cpu_ack, .cpu_rdata,
    .mem_req, .mem_valid, .mem_ack, .mem_rdata
  );

  cache_checker u_checker (
    .clk, .rst_n, .cpu_req, .cpu_valid, .cpu_ack, .cpu_rdata,
    .mem_req, .mem_valid, .errors, .checks, .completed
  );

  bind cache_top cache_properties u_props (
    .clk (clk), .rst_n (rst_n), .cpu_valid (cpu_valid), .cpu_ack (cpu_ack),
    .mem_req (mem_req), .mem_valid (mem_valid), .mem_ack (mem_ack)
  );

  task automatic issue_request();
    rnd = $random(seed);
    cpu_req.write    = rnd[7];
    cpu_req.addr.raw = {23'd0, rnd[2:0], 2'd0, rnd[4:3], rnd[6:5]};  // Tag 0..7, index 0..3
    cpu_req.wdata    = $random(seed);
    cpu_valid        = 1'b1;
  endtask

  task automatic serve_memory();
    line_key = {mem_req.line_addr[6:4], mem_req.line_addr[1:0]};
    if (mem_req.write)
      mem_lines[line_key] = mem_req.data;
    else
      mem_rdata = mem_lines[line_key];  // Held until mem_ack drops
    mem_ack = 1'b1;
  endtask

  // Memory responder with a random delay of 0 to 5 cycles
  initial begin
    mem_ack     = 1'b0;
    mem_rdata   = '0;
    mem_pending = 1'b0;
    for (int k = 0; k < 32; k++) begin
      for (int w = 0; w < cache_pkg::line_words; w++) begin
        mem_lines[k][w] = u_checker.init_word({23'd0, k[4:2], 2'd0, k[1:0], w[1:0]});
      end
    end
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        mem_ack     = 1'b0;
        mem_pending = 1'b0;
      end else if (mem_valid && !mem_ack) begin
        if (!mem_pending) begin
          mem_delay   = {$random(seed)} % 6;
          mem_pending = 1'b1;
        end
        if (mem_delay == 0) begin
          serve_memory();
          mem_pending = 1'b0;
        end else begin
          mem_delay--;
        end
      end else if (mem_ack && !mem_valid) begin
        mem_ack = 1'b0;
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    cpu_req   = '0;
    cpu_valid = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < num_reqs; n++) begin
      @(negedge clk);
      issue_request();
      @(negedge clk);
      while (!cpu_ack) @(negedge clk);
      cpu_valid = 1'b0;
      @(negedge clk);
      while (cpu_ack) @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Requests %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
             completed, num_reqs, checks, errors, DUT.u_props.fail_count);
    if (errors == 0 && DUT.u_props.fail_count == 0 && completed == num_reqs) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns with %0d of %0d requests done",
             watchdog_ns, completed, num_reqs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
